// File: compile.f
+incdir+rtl
rtl/fs_pkg.sv
rtl/axil_reg_slave.sv
rtl/frame_sync_regmap.sv
rtl/ssb_monitor.sv
rtl/frame_sync_ctrl_top.sv
tb/tb_frame_sync_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_frame_sync_ctrl
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/fs_cases.txt
# op addr_or_gap data expected, all hex
# R read and compare, W write (expected bit0 ta strobe, bit1 ta mode), P gap then pulse, I idle, M mismatch/overflow
R 000 00000000 00010061
R 004 00000000 00000f51
R 00c 00000000 46537e7e
R 010 00000000 69696969
R 008 00000000 00000000
R 7fc 00000000 00000000
W 040 12345678 00000001
W 044 00000001 00000002
W 100 ffffffff 00000002
R 100 00000000 00000000
P 000 00000000 00000000
P 01e 00000000 00000000
P 028 00000000 00000000
R 030 00000000 00000029
R 014 00000000 00000001
I 0ca 00000000 00000000
R 028 00000000 00000003
R 014 00000000 00000002
R 034 00000000 00000001
W 018 00000001 00000002
R 014 00000000 00000000
R 018 00000000 00000001
R 02c 00000000 00000000
M 085 00000001 00000000
R 024 00000000 00000085
R 01c 00000000 00000001

// File: tb/tb_frame_sync_ctrl.sv
`timescale 1ns/1ps
`include "fs_cfg.svh"

module tb_frame_sync_ctrl;

    localparam int MAX_CASES = 64;
    localparam int CLK_HALF  = 4;

    logic                  clk_i;
    logic                  reset_ni;
    logic [`FS_ADDR_W-1:0] s_axil_awaddr_i;
    logic                  s_axil_awvalid_i;
    logic                  s_axil_awready_o;
    logic [31:0]           s_axil_wdata_i;
    logic [3:0]            s_axil_wstrb_i;
    logic                  s_axil_wvalid_i;
    logic                  s_axil_wready_o;
    logic [1:0]            s_axil_bresp_o;
    logic                  s_axil_bvalid_o;
    logic                  s_axil_bready_i;
    logic [`FS_ADDR_W-1:0] s_axil_araddr_i;
    logic                  s_axil_arvalid_i;
    logic                  s_axil_arready_o;
    logic [31:0]           s_axil_rdata_o;
    logic [1:0]            s_axil_rresp_o;
    logic                  s_axil_rvalid_o;
    logic                  s_axil_rready_i;
    logic                  ssb_pulse_i;
    logic signed [7:0]     sample_cnt_mismatch_i;
    logic                  rgf_overflow_i;
    logic                  timing_advance_write_o;
    logic [31:0]           timing_advance_o;
    logic                  timing_advance_mode_o;

    // case table loaded from the data file
    logic [7:0]  case_op   [MAX_CASES];
    logic [31:0] case_arg  [MAX_CASES];
    logic [31:0] case_data [MAX_CASES];
    logic [31:0] case_exp  [MAX_CASES];
    int          num_cases;
    int          watchdog_cycles;
    logic        cases_loaded = 1'b0;

    logic [31:0] lfsr_q;
    int          ta_pulses = 0;
    logic [31:0] ta_value;

    frame_sync_ctrl_top frame_sync_ctrl_top_inst (.*);

    always #(CLK_HALF) clk_i = ~clk_i;

    // record timing-advance strobes, stable at the falling edge
    always @(negedge clk_i) begin
        if (reset_ni && timing_advance_write_o) begin
            ta_pulses = ta_pulses + 1;
            ta_value  = timing_advance_o;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // right-shifting Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // three bits, one step each
    task automatic random_delay(output int cycles);
        cycles = 0;
        for (int i = 0; i < 3; i++) begin
            cycles = (cycles << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic load_cases();
        int              fd;
        int              code;
        logic [8*16-1:0] tok;
        logic [8*160-1:0] rest;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [31:0]     e;
        fd = $fopen("tb/fs_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the case file tb/fs_cases.txt");
        end
        num_cases       = 0;
        watchdog_cycles = 100;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[7:0] == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", a, d, e);
                if (code != 3) begin
                    abort_run("a line of the case file has too few fields");
                end
                if (num_cases == MAX_CASES) begin
                    abort_run("the case file holds more lines than the table");
                end
                case_op[num_cases]   = tok[7:0];
                case_arg[num_cases]  = a;
                case_data[num_cases] = d;
                case_exp[num_cases]  = e;
                num_cases = num_cases + 1;
                // gaps count as they are, each bus transfer gets 200 cycles
                case (tok[7:0])
                    "P":      watchdog_cycles = watchdog_cycles + int'(a) + 2;
                    "I":      watchdog_cycles = watchdog_cycles + int'(a);
                    "R", "W": watchdog_cycles = watchdog_cycles + 200;
                    default:  watchdog_cycles = watchdog_cycles + 1;
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        @(negedge clk_i);
        s_axil_awaddr_i  = addr[`FS_ADDR_W-1:0];
        s_axil_awvalid_i = 1'b1;
        s_axil_wdata_i   = data;
        s_axil_wvalid_i  = 1'b1;
        while (!(s_axil_awready_o && s_axil_wready_o)) begin
            @(negedge clk_i);
        end
        // handshake happens at the rising edge in between
        @(negedge clk_i);
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
        random_delay(delay);
        repeat (delay) @(negedge clk_i);
        s_axil_bready_i = 1'b1;
        while (!s_axil_bvalid_o) begin
            @(negedge clk_i);
        end
        resp = s_axil_bresp_o;
        @(negedge clk_i);
        s_axil_bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        @(negedge clk_i);
        s_axil_araddr_i  = addr[`FS_ADDR_W-1:0];
        s_axil_arvalid_i = 1'b1;
        while (!s_axil_arready_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        s_axil_arvalid_i = 1'b0;
        random_delay(delay);
        repeat (delay) @(negedge clk_i);
        s_axil_rready_i = 1'b1;
        while (!s_axil_rvalid_o) begin
            @(negedge clk_i);
        end
        data = s_axil_rdata_o;
        resp = s_axil_rresp_o;
        @(negedge clk_i);
        s_axil_rready_i = 1'b0;
    endtask

    task automatic play_case(input int n);
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          pulses_before;
        case (case_op[n])
            "R": begin
                read_reg(case_arg[n], rdata, resp);
                check_value($sformatf("read 0x%03h", case_arg[n]), case_exp[n], rdata);
                check_value($sformatf("rresp 0x%03h", case_arg[n]), 32'd0, {30'd0, resp});
            end
            "W": begin
                pulses_before = ta_pulses;
                write_reg(case_arg[n], case_data[n], resp);
                check_value($sformatf("bresp 0x%03h", case_arg[n]), 32'd0, {30'd0, resp});
                check_value($sformatf("ta strobes 0x%03h", case_arg[n]),
                            {31'd0, case_exp[n][0]}, 32'(ta_pulses - pulses_before));
                if (case_exp[n][0]) begin
                    check_value("ta value", case_data[n], ta_value);
                end
                check_value($sformatf("ta mode 0x%03h", case_arg[n]),
                            {31'd0, case_exp[n][1]}, {31'd0, timing_advance_mode_o});
            end
            "P": begin
                repeat (case_arg[n]) @(negedge clk_i);
                ssb_pulse_i = 1'b1;
                @(negedge clk_i);
                ssb_pulse_i = 1'b0;
            end
            "I": begin
                repeat (case_arg[n]) @(negedge clk_i);
            end
            "M": begin
                sample_cnt_mismatch_i = case_arg[n][7:0];
                rgf_overflow_i        = case_data[n][0];
            end
            default: abort_run($sformatf("unknown opcode on case %0d", n));
        endcase
    endtask

    initial begin
        wait (cases_loaded);
        repeat (watchdog_cycles) @(posedge clk_i);
        abort_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
    end

    initial begin
        clk_i                 = 1'b0;
        reset_ni              = 1'b0;
        s_axil_awaddr_i       = '0;
        s_axil_awvalid_i      = 1'b0;
        s_axil_wdata_i        = 32'd0;
        s_axil_wstrb_i        = 4'hF;
        s_axil_wvalid_i       = 1'b0;
        s_axil_bready_i       = 1'b0;
        s_axil_araddr_i       = '0;
        s_axil_arvalid_i      = 1'b0;
        s_axil_rready_i       = 1'b0;
        ssb_pulse_i           = 1'b0;
        sample_cnt_mismatch_i = 8'sd0;
        rgf_overflow_i        = 1'b0;
        lfsr_q                = 32'habdd;
        load_cases();
        cases_loaded = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;
        for (int n = 0; n < num_cases; n++) begin
            play_case(n);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: rtl/frame_sync_ctrl_top.sv
`timescale 1ns/1ps
`include "fs_cfg.svh"

module frame_sync_ctrl_top (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic [`FS_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                  s_axil_awvalid_i,
    output logic                  s_axil_awready_o,
    input  logic [31:0]           s_axil_wdata_i,
    input  logic [3:0]            s_axil_wstrb_i,
    input  logic                  s_axil_wvalid_i,
    output logic                  s_axil_wready_o,
    output logic [1:0]            s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  logic                  s_axil_bready_i,
    input  logic [`FS_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                  s_axil_arvalid_i,
    output logic                  s_axil_arready_o,
    output logic [31:0]           s_axil_rdata_o,
    output logic [1:0]            s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  logic                  s_axil_rready_i,

    // sensor side
    input  logic                  ssb_pulse_i,
    input  logic signed [7:0]     sample_cnt_mismatch_i,
    input  logic                  rgf_overflow_i,

    // control outputs
    output logic                  timing_advance_write_o,
    output logic [31:0]           timing_advance_o,
    output logic                  timing_advance_mode_o
);

    import frame_sync_pkg::*;

    reg_req_t   wreq;
    reg_req_t   rreq;
    reg_rsp_t   rrsp;
    logic       wack;
    fs_status_t status;
    logic       reconnect_mode_write;
    logic [1:0] reconnect_mode;

    axil_reg_slave #(
        .ADDR_W(`FS_ADDR_W)
    ) axil_reg_slave_inst (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .s_axil_awaddr_i (s_axil_awaddr_i),
        .s_axil_awvalid_i(s_axil_awvalid_i),
        .s_axil_awready_o(s_axil_awready_o),
        .s_axil_wdata_i  (s_axil_wdata_i),
        .s_axil_wstrb_i  (s_axil_wstrb_i),
        .s_axil_wvalid_i (s_axil_wvalid_i),
        .s_axil_wready_o (s_axil_wready_o),
        .s_axil_bresp_o  (s_axil_bresp_o),
        .s_axil_bvalid_o (s_axil_bvalid_o),
        .s_axil_bready_i (s_axil_bready_i),
        .s_axil_araddr_i (s_axil_araddr_i),
        .s_axil_arvalid_i(s_axil_arvalid_i),
        .s_axil_arready_o(s_axil_arready_o),
        .s_axil_rdata_o  (s_axil_rdata_o),
        .s_axil_rresp_o  (s_axil_rresp_o),
        .s_axil_rvalid_o (s_axil_rvalid_o),
        .s_axil_rready_i (s_axil_rready_i),
        .wreq_o          (wreq),
        .wack_i          (wack),
        .rreq_o          (rreq),
        .rrsp_i          (rrsp)
    );

    frame_sync_regmap frame_sync_regmap_inst (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .wreq_i                (wreq),
        .wack_o                (wack),
        .rreq_i                (rreq),
        .rrsp_o                (rrsp),
        .status_i              (status),
        .sample_cnt_mismatch_i (sample_cnt_mismatch_i),
        .rgf_overflow_i        (rgf_overflow_i),
        .reconnect_mode_write_o(reconnect_mode_write),
        .reconnect_mode_o      (reconnect_mode),
        .timing_advance_write_o(timing_advance_write_o),
        .timing_advance_o      (timing_advance_o),
        .timing_advance_mode_o (timing_advance_mode_o)
    );

    ssb_monitor ssb_monitor_inst (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .ssb_pulse_i           (ssb_pulse_i),
        .reconnect_mode_write_i(reconnect_mode_write),
        .reconnect_mode_i      (reconnect_mode),
        .status_o              (status)
    );

endmodule

// File: rtl/ssb_monitor.sv
`timescale 1ns/1ps
`include "fs_cfg.svh"

module ssb_monitor (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       ssb_pulse_i,
    input  logic                       reconnect_mode_write_i,
    input  logic [1:0]                 reconnect_mode_i,
    output frame_sync_pkg::fs_status_t status_o
);

    import frame_sync_pkg::*;

    localparam int MISS_W = $clog2(`FS_MISS_LIMIT + 1);

    fs_state_e         state_q;
    logic [31:0]       clk_cnt_q;
    logic [31:0]       clks_btwn_q;
    logic [15:0]       missed_q;
    logic [MISS_W-1:0] miss_run_q;
    logic [31:0]       disconnects_q;
    logic [1:0]        reconnect_mode_q;
    logic [1:0]        reconnect_mode_next;
    logic              timeout;
    logic              lock_lost;

    // a full timeout window passed without a pulse
    assign timeout = !ssb_pulse_i && (clk_cnt_q == `FS_SSB_TIMEOUT - 1);

    assign lock_lost = timeout && (state_q == LOCKED)
                       && (miss_run_q == MISS_W'(`FS_MISS_LIMIT - 1));

    assign reconnect_mode_next = reconnect_mode_write_i ? reconnect_mode_i : reconnect_mode_q;

    // interval and miss counting
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            clk_cnt_q   <= 32'd0;
            clks_btwn_q <= 32'd0;
            missed_q    <= 16'd0;
            miss_run_q  <= '0;
        end else if (ssb_pulse_i) begin
            clks_btwn_q <= clk_cnt_q + 32'd1;
            clk_cnt_q   <= 32'd0;
            miss_run_q  <= '0;
        end else if (timeout) begin
            clk_cnt_q <= 32'd0;
            // misses only count while tracking
            if (state_q == LOCKED) begin
                missed_q   <= missed_q + 16'd1;
                miss_run_q <= miss_run_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 32'd1;
        end
    end

    // lock FSM
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q          <= SEARCH;
            disconnects_q    <= 32'd0;
            reconnect_mode_q <= 2'd0;
        end else begin
            reconnect_mode_q <= reconnect_mode_next;
            case (state_q)
                SEARCH: if (ssb_pulse_i) state_q <= LOCKED;
                LOCKED: begin
                    if (lock_lost) begin
                        state_q       <= LOST;
                        disconnects_q <= disconnects_q + 32'd1;
                    end
                end
                LOST: if (reconnect_mode_next == 2'd1) state_q <= SEARCH;
                default: state_q <= SEARCH;
            endcase
        end
    end

    assign status_o = '{
        fs_state:        state_q,
        reconnect_mode:  reconnect_mode_q,
        missed_ssbs:     missed_q,
        clks_btwn_ssbs:  clks_btwn_q,
        num_disconnects: disconnects_q
    };

endmodule

// File: rtl/frame_sync_regmap.sv
`timescale 1ns/1ps
`include "fs_cfg.svh"

module frame_sync_regmap (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    input  frame_sync_pkg::reg_req_t   wreq_i,
    output logic                       wack_o,
    input  frame_sync_pkg::reg_req_t   rreq_i,
    output frame_sync_pkg::reg_rsp_t   rrsp_o,

    // mapped status
    input  frame_sync_pkg::fs_status_t status_i,
    input  logic signed [7:0]          sample_cnt_mismatch_i,
    input  logic                       rgf_overflow_i,

    // control strobes
    output logic                       reconnect_mode_write_o,
    output logic [1:0]                 reconnect_mode_o,
    output logic                       timing_advance_write_o,
    output logic [31:0]                timing_advance_o,
    output logic                       timing_advance_mode_o
);

    import frame_sync_pkg::*;

    logic        rack_q;
    logic [31:0] rdata_q;
    logic        wack_q;
    logic        ta_mode_q;

    // acknowledge one cycle after each request
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rack_q <= 1'b0;
            wack_q <= 1'b0;
        end else begin
            rack_q <= rreq_i.valid;
            wack_q <= wreq_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rreq_i.valid) begin
            case (rreq_i.index)
                REG_VERSION:         rdata_q <= `FS_VERSION;
                REG_CORE_ID:         rdata_q <= `FS_CORE_ID;
                REG_MAGIC0:          rdata_q <= `FS_MAGIC0;
                REG_MAGIC1:          rdata_q <= `FS_MAGIC1;
                REG_FS_STATE:        rdata_q <= {30'd0, status_i.fs_state};
                REG_RECONNECT_MODE:  rdata_q <= {30'd0, status_i.reconnect_mode};
                REG_RGF_OVERFLOW:    rdata_q <= {31'd0, rgf_overflow_i};
                // zero-extended, sign is not carried
                REG_SAMPLE_MISMATCH: rdata_q <= {24'd0, sample_cnt_mismatch_i};
                REG_MISSED_SSBS:     rdata_q <= {16'd0, status_i.missed_ssbs};
                REG_CLKS_BTWN_SSBS:  rdata_q <= status_i.clks_btwn_ssbs;
                REG_NUM_DISCONNECTS: rdata_q <= status_i.num_disconnects;
                // ssb index has no source here, reads zero with the unmapped words
                default:             rdata_q <= 32'd0;
            endcase
        end
    end

    assign rrsp_o = '{ack: rack_q, data: rdata_q};
    assign wack_o = wack_q;

    // write strobes pulse in the request cycle
    assign reconnect_mode_write_o = wreq_i.valid && (wreq_i.index == REG_RECONNECT_MODE);
    assign reconnect_mode_o       = wreq_i.data[1:0];
    assign timing_advance_write_o = wreq_i.valid && (wreq_i.index == REG_TIMING_ADVANCE);
    assign timing_advance_o       = wreq_i.data;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ta_mode_q <= 1'b0;
        end else if (wreq_i.valid && wreq_i.index == REG_TA_MODE) begin
            ta_mode_q <= wreq_i.data[0];
        end
    end

    assign timing_advance_mode_o = ta_mode_q;

    a_ack_follows_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (rreq_i.valid |=> rrsp_o.ack && !$past(rrsp_o.ack))
        and (wreq_i.valid |=> wack_o && !$past(wack_o)));

endmodule

// File: rtl/axil_reg_slave.sv
`timescale 1ns/1ps
`include "fs_cfg.svh"

module axil_reg_slave #(
    parameter int ADDR_W = `FS_ADDR_W
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    // write address and data
    input  logic [ADDR_W-1:0]        s_axil_awaddr_i,
    input  logic                     s_axil_awvalid_i,
    output logic                     s_axil_awready_o,
    input  logic [31:0]              s_axil_wdata_i,
    input  logic [3:0]               s_axil_wstrb_i,
    input  logic                     s_axil_wvalid_i,
    output logic                     s_axil_wready_o,

    // write response
    output logic [1:0]               s_axil_bresp_o,
    output logic                     s_axil_bvalid_o,
    input  logic                     s_axil_bready_i,

    // read address and data
    input  logic [ADDR_W-1:0]        s_axil_araddr_i,
    input  logic                     s_axil_arvalid_i,
    output logic                     s_axil_arready_o,
    output logic [31:0]              s_axil_rdata_o,
    output logic [1:0]               s_axil_rresp_o,
    output logic                     s_axil_rvalid_o,
    input  logic                     s_axil_rready_i,

    // register side
    output frame_sync_pkg::reg_req_t wreq_o,
    input  logic                     wack_i,
    output frame_sync_pkg::reg_req_t rreq_o,
    input  frame_sync_pkg::reg_rsp_t rrsp_i
);

    import frame_sync_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } xfer_state_e;

    xfer_state_e w_state_q;
    xfer_state_e r_state_q;

    logic        aw_ready_q;
    logic        bvalid_q;
    logic        wreq_valid_q;
    logic [8:0]  widx_q;
    logic [31:0] wdata_q;

    logic        ar_ready_q;
    logic        rvalid_q;
    logic        rreq_valid_q;
    logic [8:0]  ridx_q;
    logic [31:0] rdata_q;

    logic        w_accept;
    logic        r_accept;

    // address and data are taken together
    assign w_accept = s_axil_awvalid_i && s_axil_wvalid_i && aw_ready_q;
    assign r_accept = s_axil_arvalid_i && ar_ready_q;

    // write channel
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            w_state_q    <= ST_IDLE;
            aw_ready_q   <= 1'b0;
            bvalid_q     <= 1'b0;
            wreq_valid_q <= 1'b0;
        end else begin
            case (w_state_q)
                ST_IDLE: begin
                    if (w_accept) begin
                        aw_ready_q   <= 1'b0;
                        wreq_valid_q <= 1'b1;
                        w_state_q    <= ST_REQ;
                    end else begin
                        aw_ready_q <= 1'b1;
                    end
                end
                ST_REQ: begin
                    wreq_valid_q <= 1'b0;
                    w_state_q    <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (wack_i) begin
                        bvalid_q  <= 1'b1;
                        w_state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axil_bready_i) begin
                        bvalid_q   <= 1'b0;
                        aw_ready_q <= 1'b1;
                        w_state_q  <= ST_IDLE;
                    end
                end
                default: w_state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_accept) begin
            widx_q  <= s_axil_awaddr_i[ADDR_W-1:2];
            wdata_q <= s_axil_wdata_i;
        end
    end

    // read channel
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            r_state_q    <= ST_IDLE;
            ar_ready_q   <= 1'b0;
            rvalid_q     <= 1'b0;
            rreq_valid_q <= 1'b0;
        end else begin
            case (r_state_q)
                ST_IDLE: begin
                    if (r_accept) begin
                        ar_ready_q   <= 1'b0;
                        rreq_valid_q <= 1'b1;
                        r_state_q    <= ST_REQ;
                    end else begin
                        ar_ready_q <= 1'b1;
                    end
                end
                ST_REQ: begin
                    rreq_valid_q <= 1'b0;
                    r_state_q    <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (rrsp_i.ack) begin
                        rvalid_q  <= 1'b1;
                        r_state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axil_rready_i) begin
                        rvalid_q   <= 1'b0;
                        ar_ready_q <= 1'b1;
                        r_state_q  <= ST_IDLE;
                    end
                end
                default: r_state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_accept) begin
            ridx_q <= s_axil_araddr_i[ADDR_W-1:2];
        end
        if (r_state_q == ST_WAIT && rrsp_i.ack) begin
            rdata_q <= rrsp_i.data;
        end
    end

    assign s_axil_awready_o = aw_ready_q;
    assign s_axil_wready_o  = aw_ready_q;
    assign s_axil_bvalid_o  = bvalid_q;
    assign s_axil_bresp_o   = 2'b00;
    assign s_axil_arready_o = ar_ready_q;
    assign s_axil_rvalid_o  = rvalid_q;
    assign s_axil_rdata_o   = rdata_q;
    assign s_axil_rresp_o   = 2'b00;

    assign wreq_o = '{valid: wreq_valid_q, index: widx_q, data: wdata_q};
    assign rreq_o = '{valid: rreq_valid_q, index: ridx_q, data: 32'd0};

    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o);

    a_req_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (wreq_o.valid |=> !wreq_o.valid) and (rreq_o.valid |=> !rreq_o.valid));

endmodule

// File: rtl/fs_pkg.sv
package frame_sync_pkg;

    // lock state of the synchronizer
    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        LOCKED = 2'd1,
        LOST   = 2'd2
    } fs_state_e;

    // word indexes of the register map
    typedef enum logic [8:0] {
        REG_VERSION         = 9'h000,
        REG_CORE_ID         = 9'h001,
        REG_RSVD_002        = 9'h002,
        REG_MAGIC0          = 9'h003,
        REG_MAGIC1          = 9'h004,
        REG_FS_STATE        = 9'h005,
        REG_RECONNECT_MODE  = 9'h006,
        REG_RGF_OVERFLOW    = 9'h007,
        REG_RSVD_008        = 9'h008,
        REG_SAMPLE_MISMATCH = 9'h009,
        REG_MISSED_SSBS     = 9'h00A,
        REG_IBAR_SSB        = 9'h00B,
        REG_CLKS_BTWN_SSBS  = 9'h00C,
        REG_NUM_DISCONNECTS = 9'h00D,
        REG_RSVD_00E        = 9'h00E,
        REG_RSVD_00F        = 9'h00F,
        REG_TIMING_ADVANCE  = 9'h010,
        REG_TA_MODE         = 9'h011
    } reg_idx_e;

    // single-cycle register request, read or write
    typedef struct packed {
        logic        valid;
        logic [8:0]  index;
        logic [31:0] data;
    } reg_req_t;

    // read acknowledge with data
    typedef struct packed {
        logic        ack;
        logic [31:0] data;
    } reg_rsp_t;

    typedef struct packed {
        fs_state_e   fs_state;
        logic [1:0]  reconnect_mode;
        logic [15:0] missed_ssbs;
        logic [31:0] clks_btwn_ssbs;
        logic [31:0] num_disconnects;
    } fs_status_t;

endpackage

// File: rtl/fs_cfg.svh
`ifndef FS_CFG_SVH
`define FS_CFG_SVH

// AXI4-Lite byte address width, bits 10:2 form the word index
`define FS_ADDR_W 11

// identification words
`define FS_VERSION 32'h0001_0061
`define FS_CORE_ID 32'h0000_0F51
// "FS~~"
`define FS_MAGIC0 32'h4653_7E7E
`define FS_MAGIC1 32'h6969_6969

// clocks without an SSB pulse before one SSB is counted as missed
`define FS_SSB_TIMEOUT 64

// consecutive misses that drop lock
`define FS_MISS_LIMIT 3

`endif
